/* conv3x3.f */
common/conv_pkg.sv
window_gen/window_gen.sv
hdl/kernel_bank.sv
conv_engine/conv_mac.sv
hdl/pixel_normalize.sv
hdl/conv3x3_top.sv
bench/conv3x3_tb.sv

/* Makefile */
# Verilator build for the 3x3 convolution

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module conv3x3_top -f conv3x3.f

sim:
	verilator --binary --timing --assert --top-module conv3x3_tb -f conv3x3.f -o conv3x3_sim
	./obj_dir/conv3x3_sim > sim.log 2>&1; cat sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/conv3x3_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv3x3_tb import conv_pkg::*; ();

  localparam int TIMEOUT = 4000;
  localparam int OUTS_PER_FRAME = (IMG_W - 2) * (IMG_H - 2);

  logic                  clk;
  logic                  reset;
  logic [PIX_W-1:0]      pixel;
  logic                  pixel_valid;
  logic                  frame_start;
  logic                  kernel_we;
  logic [TAP_ADDR_W-1:0] kernel_addr;
  logic [COEF_W-1:0]     kernel_data;
  logic                  kernel_commit;
  logic [SHIFT_W-1:0]    norm_shift;
  wire  [PIX_W-1:0]      out_pixel;
  wire                   out_valid;

  // software copy of the frame, both kernel sets and the shift amount
  int img [IMG_H][IMG_W];
  int shadow_k [TAPS];
  int active_k [TAPS];
  int next_k [TAPS];
  int shift_m;

  int               exp_q [$];
  logic [PIX_W-1:0] exp_head;
  logic             exp_empty;
  logic             pop_pending;
  logic [31:0]      rng;
  int               errors;
  int               tests;
  int               cycles;
  int               frame_outs;

  conv3x3_top conv3x3_top_inst (
    .clk(clk), .reset(reset),
    .pixel(pixel), .pixel_valid(pixel_valid), .frame_start(frame_start),
    .kernel_we(kernel_we), .kernel_addr(kernel_addr),
    .kernel_data(kernel_data), .kernel_commit(kernel_commit),
    .norm_shift(norm_shift),
    .out_pixel(out_pixel), .out_valid(out_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run timed out after %0d cycles with outputs still missing", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // outputs are checked at the falling edge and retired at the next rising edge
  always @(negedge clk) begin
    pop_pending = out_valid;
    if (out_valid) begin
      frame_outs++;
    end
  end

  always @(posedge clk) begin
    if (pop_pending && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      exp_empty = (exp_q.size() == 0);
      if (!exp_empty) begin
        exp_head = PIX_W'(exp_q[0]);
      end
    end
    pop_pending = 1'b0;
  end

  a_out_matches: assert property (
    @(negedge clk) disable iff (reset)
    (out_valid && !exp_empty) |-> (out_pixel == exp_head)
  ) else begin
    $display("[ERROR] %0t ns: out_pixel expected %0d, got %0d", $time, exp_head, out_pixel);
    errors++;
  end

  a_out_expected: assert property (
    @(negedge clk) disable iff (reset)
    out_valid |-> !exp_empty
  ) else begin
    $display("at %0t ns out_valid came while no output was expected", $time);
    errors++;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // window centred one line and one column behind the newest pixel
  function automatic int expected_out(input int r, input int c);
    int acc;
    acc = 0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        acc += img[r - 2 + i][c - 2 + j] * active_k[3 * i + j];
      end
    end
    acc = acc >> shift_m;
    return (acc > 255) ? 255 : acc;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic next_rand(input int n, output int value);
    rng = xorshift(rng);
    value = int'(rng % 32'(n));
  endtask

  task automatic push_expected(input int value);
    exp_q.push_back(value);
    exp_head = PIX_W'(exp_q[0]);
    exp_empty = 1'b0;
  endtask

  task automatic fill_frame(input int lo, input int span);
    int v;
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        next_rand(span, v);
        img[r][c] = lo + v;
      end
    end
  endtask

  task automatic fill_kernel(input int outer, input int centre);
    for (int t = 0; t < TAPS; t++) begin
      next_k[t] = (t == 4) ? centre : outer;
    end
  endtask

  task automatic write_shadow();
    for (int t = 0; t < TAPS; t++) begin
      kernel_we = 1'b1;
      kernel_addr = TAP_ADDR_W'(t);
      kernel_data = COEF_W'(next_k[t]);
      shadow_k[t] = next_k[t];
      step();
    end
    kernel_we = 1'b0;
  endtask

  task automatic commit_kernel(input int shift);
    norm_shift = SHIFT_W'(shift);
    shift_m = shift;
    kernel_commit = 1'b1;
    step();
    kernel_commit = 1'b0;
    active_k = shadow_k;
  endtask

  // mid_load writes next_k into the shadow set halfway down the frame
  task automatic drive_frame(input int max_gap, input bit mid_load);
    int gap;
    frame_outs = 0;
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        if (mid_load && r == IMG_H / 2 && c == 0) begin
          write_shadow();
        end
        next_rand(max_gap + 1, gap);
        repeat (gap) step();
        pixel = PIX_W'(img[r][c]);
        pixel_valid = 1'b1;
        frame_start = (r == 0 && c == 0);
        if (r >= 2 && c >= 2) begin
          push_expected(expected_out(r, c));
        end
        step();
        pixel_valid = 1'b0;
        frame_start = 1'b0;
      end
    end
    while (exp_q.size() != 0) step();
    repeat (8) step();
    a_frame_count: assert (frame_outs == OUTS_PER_FRAME) else begin
      $display("[ERROR] %0t ns: frame gave %0d outputs, expected %0d",
               $time, frame_outs, OUTS_PER_FRAME);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
  endtask

  initial begin
    int err_mark;
    clk = 1'b0;
    reset = 1'b1;
    pixel = '0;
    pixel_valid = 1'b0;
    frame_start = 1'b0;
    kernel_we = 1'b0;
    kernel_addr = '0;
    kernel_data = '0;
    kernel_commit = 1'b0;
    norm_shift = '0;
    shift_m = 0;
    rng = 32'd62469;
    errors = 0;
    tests = 0;
    cycles = 0;
    frame_outs = 0;
    exp_head = '0;
    exp_empty = 1'b1;
    pop_pending = 1'b0;
    shadow_k = '{default: 0};
    active_k = '{default: 0};
    next_k = '{default: 0};
    repeat (3) step();
    reset = 1'b0;
    step();

    err_mark = errors;
    fill_kernel(0, 1);
    write_shadow();
    commit_kernel(0);
    fill_frame(0, 256);
    drive_frame(3, 1'b0);
    report_test("identity kernel", err_mark);

    err_mark = errors;
    fill_kernel(1, 1);
    write_shadow();
    commit_kernel(3);
    fill_frame(0, 256);
    drive_frame(3, 1'b0);
    report_test("box filter", err_mark);

    // nine full-scale products must survive the adder tree before clamping
    err_mark = errors;
    fill_kernel(255, 255);
    write_shadow();
    commit_kernel(0);
    fill_frame(200, 56);
    drive_frame(3, 1'b0);
    report_test("saturation", err_mark);

    err_mark = errors;
    fill_kernel(1, 1);
    write_shadow();
    commit_kernel(3);
    fill_kernel(1, 8);
    fill_frame(0, 256);
    drive_frame(3, 1'b1);
    commit_kernel(4);
    fill_frame(0, 256);
    drive_frame(3, 1'b0);
    report_test("shadow commit", err_mark);

    err_mark = errors;
    fill_frame(0, 256);
    drive_frame(4, 1'b0);
    report_test("output count", err_mark);

    $display("tests run: %0d, failed checks: %0d", tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/conv3x3_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv3x3_top import conv_pkg::*; (
  input  wire                   clk,
  input  wire                   reset,
  input  wire  [PIX_W-1:0]      pixel,
  input  wire                   pixel_valid,
  input  wire                   frame_start,
  input  wire                   kernel_we,
  input  wire  [TAP_ADDR_W-1:0] kernel_addr,
  input  wire  [COEF_W-1:0]     kernel_data,
  input  wire                   kernel_commit,
  input  wire  [SHIFT_W-1:0]    norm_shift,
  output logic [PIX_W-1:0]      out_pixel,
  output logic                  out_valid
);

  logic [PIX_W-1:0]  win_0, win_1, win_2, win_3, win_4, win_5, win_6, win_7, win_8;
  logic              win_valid;
  logic [COEF_W-1:0] coef_0, coef_1, coef_2, coef_3, coef_4, coef_5, coef_6, coef_7;
  logic [COEF_W-1:0] coef_8;
  logic [SUM_W-1:0]  sum;
  logic              sum_valid;

  window_gen window_gen_inst (
    .clk(clk), .reset(reset),
    .pixel(pixel), .pixel_valid(pixel_valid), .frame_start(frame_start),
    .win_0(win_0), .win_1(win_1), .win_2(win_2),
    .win_3(win_3), .win_4(win_4), .win_5(win_5),
    .win_6(win_6), .win_7(win_7), .win_8(win_8),
    .win_valid(win_valid)
  );

  kernel_bank kernel_bank_inst (
    .clk(clk), .reset(reset),
    .kernel_we(kernel_we), .kernel_addr(kernel_addr),
    .kernel_data(kernel_data), .kernel_commit(kernel_commit),
    .coef_0(coef_0), .coef_1(coef_1), .coef_2(coef_2),
    .coef_3(coef_3), .coef_4(coef_4), .coef_5(coef_5),
    .coef_6(coef_6), .coef_7(coef_7), .coef_8(coef_8)
  );

  conv_mac conv_mac_inst (
    .clk(clk), .reset(reset),
    .win_0(win_0), .win_1(win_1), .win_2(win_2),
    .win_3(win_3), .win_4(win_4), .win_5(win_5),
    .win_6(win_6), .win_7(win_7), .win_8(win_8),
    .win_valid(win_valid),
    .coef_0(coef_0), .coef_1(coef_1), .coef_2(coef_2),
    .coef_3(coef_3), .coef_4(coef_4), .coef_5(coef_5),
    .coef_6(coef_6), .coef_7(coef_7), .coef_8(coef_8),
    .sum(sum), .sum_valid(sum_valid)
  );

  pixel_normalize pixel_normalize_inst (
    .clk(clk), .reset(reset),
    .sum(sum), .sum_valid(sum_valid), .norm_shift(norm_shift),
    .out_pixel(out_pixel), .out_valid(out_valid)
  );

endmodule

`default_nettype wire

/* hdl/pixel_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_normalize import conv_pkg::*; (
  input  wire                clk,
  input  wire                reset,
  input  wire  [SUM_W-1:0]   sum,
  input  wire                sum_valid,
  input  wire  [SHIFT_W-1:0] norm_shift,
  output logic [PIX_W-1:0]   out_pixel,
  output logic               out_valid
);

  logic [SUM_W-1:0] shifted;
  logic             overflow;

  assign shifted  = sum >> norm_shift;
  // anything above the pixel range clamps to full white
  assign overflow = |shifted[SUM_W-1:PIX_W];

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      out_pixel <= overflow ? {PIX_W{1'b1}} : shifted[PIX_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  a_out_valid_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(out_valid)
  );

endmodule

`default_nettype wire

/* conv_engine/conv_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac import conv_pkg::*; (
  input  wire               clk,
  input  wire               reset,
  input  wire  [PIX_W-1:0]  win_0,
  input  wire  [PIX_W-1:0]  win_1,
  input  wire  [PIX_W-1:0]  win_2,
  input  wire  [PIX_W-1:0]  win_3,
  input  wire  [PIX_W-1:0]  win_4,
  input  wire  [PIX_W-1:0]  win_5,
  input  wire  [PIX_W-1:0]  win_6,
  input  wire  [PIX_W-1:0]  win_7,
  input  wire  [PIX_W-1:0]  win_8,
  input  wire               win_valid,
  input  wire  [COEF_W-1:0] coef_0,
  input  wire  [COEF_W-1:0] coef_1,
  input  wire  [COEF_W-1:0] coef_2,
  input  wire  [COEF_W-1:0] coef_3,
  input  wire  [COEF_W-1:0] coef_4,
  input  wire  [COEF_W-1:0] coef_5,
  input  wire  [COEF_W-1:0] coef_6,
  input  wire  [COEF_W-1:0] coef_7,
  input  wire  [COEF_W-1:0] coef_8,
  output logic [SUM_W-1:0]  sum,
  output logic              sum_valid
);

  logic [PIX_W-1:0]  win  [TAPS];
  logic [COEF_W-1:0] coef [TAPS];
  logic [PROD_W-1:0] prod [TAPS];
  logic [PROD_W:0]   pair [5];
  logic              prod_valid;
  logic              pair_valid;

  assign win  = '{win_0, win_1, win_2, win_3, win_4, win_5, win_6, win_7, win_8};
  assign coef = '{coef_0, coef_1, coef_2, coef_3, coef_4, coef_5, coef_6, coef_7,
                  coef_8};

  // stage 1 registers the nine products
  always_ff @(posedge clk) begin
    for (int i = 0; i < TAPS; i++) begin
      prod[i] <= PROD_W'(win[i]) * PROD_W'(coef[i]);
    end
  end

  // stage 2 adds neighbouring products, tap 8 rides along alone
  always_ff @(posedge clk) begin
    pair[0] <= {1'b0, prod[0]} + {1'b0, prod[1]};
    pair[1] <= {1'b0, prod[2]} + {1'b0, prod[3]};
    pair[2] <= {1'b0, prod[4]} + {1'b0, prod[5]};
    pair[3] <= {1'b0, prod[6]} + {1'b0, prod[7]};
    pair[4] <= {1'b0, prod[8]};
  end

  // stage 3 finishes the tree at full width
  always_ff @(posedge clk) begin
    sum <= SUM_W'(pair[0]) + SUM_W'(pair[1]) + SUM_W'(pair[2]) + SUM_W'(pair[3]) +
           SUM_W'(pair[4]);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      pair_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      pair_valid <= prod_valid;
      sum_valid  <= pair_valid;
    end
  end

  // a valid sum never carries unknown bits from the window or the kernel
  a_sum_known: assert property (
    @(posedge clk) disable iff (reset)
    sum_valid |-> !$isunknown(sum)
  );

endmodule

`default_nettype wire

/* hdl/kernel_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_bank import conv_pkg::*; (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   kernel_we,
  input  wire  [TAP_ADDR_W-1:0] kernel_addr,
  input  wire  [COEF_W-1:0]     kernel_data,
  input  wire                   kernel_commit,
  output logic [COEF_W-1:0]     coef_0,
  output logic [COEF_W-1:0]     coef_1,
  output logic [COEF_W-1:0]     coef_2,
  output logic [COEF_W-1:0]     coef_3,
  output logic [COEF_W-1:0]     coef_4,
  output logic [COEF_W-1:0]     coef_5,
  output logic [COEF_W-1:0]     coef_6,
  output logic [COEF_W-1:0]     coef_7,
  output logic [COEF_W-1:0]     coef_8
);

  logic [COEF_W-1:0] shadow [TAPS];
  logic [COEF_W-1:0] active [TAPS];

  // software loads the shadow set while the active set keeps feeding the engine
  always_ff @(posedge clk) begin
    if (reset) begin
      shadow <= '{default: '0};
      active <= '{default: '0};
    end else begin
      if (kernel_we && (kernel_addr < TAP_ADDR_W'(TAPS))) begin
        shadow[kernel_addr] <= kernel_data;
      end
      // all nine taps switch in the same cycle
      if (kernel_commit) begin
        active <= shadow;
      end
    end
  end

  assign coef_0 = active[0];
  assign coef_1 = active[1];
  assign coef_2 = active[2];
  assign coef_3 = active[3];
  assign coef_4 = active[4];
  assign coef_5 = active[5];
  assign coef_6 = active[6];
  assign coef_7 = active[7];
  assign coef_8 = active[8];

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    kernel_we |-> (kernel_addr < TAP_ADDR_W'(TAPS))
  );

endmodule

`default_nettype wire

/* window_gen/window_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module window_gen import conv_pkg::*; (
  input  wire              clk,
  input  wire              reset,
  input  wire  [PIX_W-1:0] pixel,
  input  wire              pixel_valid,
  input  wire              frame_start,
  output logic [PIX_W-1:0] win_0,
  output logic [PIX_W-1:0] win_1,
  output logic [PIX_W-1:0] win_2,
  output logic [PIX_W-1:0] win_3,
  output logic [PIX_W-1:0] win_4,
  output logic [PIX_W-1:0] win_5,
  output logic [PIX_W-1:0] win_6,
  output logic [PIX_W-1:0] win_7,
  output logic [PIX_W-1:0] win_8,
  output logic             win_valid
);

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic [COL_W-1:0] cur_col;
  logic [ROW_W-1:0] cur_row;
  logic             window_full;

  // line1 holds the previous line, line2 the one before it
  logic [PIX_W-1:0] line1 [IMG_W];
  logic [PIX_W-1:0] line2 [IMG_W];

  // the first pixel of a frame always sits at row 0, column 0
  assign cur_col = frame_start ? '0 : col_cnt;
  assign cur_row = frame_start ? '0 : row_cnt;

  assign window_full = (cur_col >= COL_W'(2)) && (cur_row >= ROW_W'(2));

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt   <= '0;
      row_cnt   <= '0;
      win_valid <= 1'b0;
    end else begin
      win_valid <= pixel_valid && window_full;
      if (pixel_valid) begin
        if (cur_col == COL_W'(IMG_W - 1)) begin
          col_cnt <= '0;
          row_cnt <= cur_row + ROW_W'(1);
        end else begin
          col_cnt <= cur_col + COL_W'(1);
          row_cnt <= cur_row;
        end
      end
    end
  end

  // line delays are addressed by column, so each entry ages by exactly one line
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      line2[cur_col] <= line1[cur_col];
      line1[cur_col] <= pixel;
    end
  end

  // shift the window one column left, the new column enters on the right
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      win_0 <= win_1;
      win_1 <= win_2;
      win_2 <= line2[cur_col];
      win_3 <= win_4;
      win_4 <= win_5;
      win_5 <= line1[cur_col];
      win_6 <= win_7;
      win_7 <= win_8;
      win_8 <= pixel;
    end
  end

  // a frame start outside a pixel strobe would leave the counters out of step
  a_frame_start_with_valid: assert property (
    @(posedge clk) disable iff (reset)
    frame_start |-> pixel_valid
  );

endmodule

`default_nettype wire

/* common/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // pixel and coefficient formats, both unsigned
  localparam int PIX_W  = 8;
  localparam int COEF_W = 8;

  // 3x3 kernel, taps numbered row-major from the top-left
  localparam int TAPS = 9;

  // fixed frame geometry
  localparam int IMG_W = 16;
  localparam int IMG_H = 8;
  localparam int COL_W = $clog2(IMG_W);
  localparam int ROW_W = $clog2(IMG_H);

  // datapath widths through the multiply and the adder tree
  localparam int PROD_W = PIX_W + COEF_W;

  // nine full-scale products need four bits above the product width
  localparam int SUM_W = 20;

  // normalize shift amount
  localparam int SHIFT_W = 4;

  // coefficient write address
  localparam int TAP_ADDR_W = 4;

endpackage

`default_nettype wire
